/* Makefile */
# Verilator build and run for the memory stage testbench

VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= mem_stage_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
SOURCES   ?= $(wildcard hdl/*.sv verification/*.sv include/*.svh)

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

# exit status of the simulator is the test result
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* hdl/data_ram.sv */
// byte-masked 64-bit word RAM with registered read
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module data_ram (
    input  logic                       clk,
    input  logic                       ram_rd_en,
    input  logic                       ram_wr_en,
    input  logic [`DMEM_ADDR_BITS-1:0] ram_index,
    input  logic [`XLEN-1:0]           ram_wdata,
    input  logic [`XLEN/8-1:0]         ram_wmask,   // one bit per byte lane
    output logic [`XLEN-1:0]           ram_rdata
);

    logic [`XLEN-1:0] mem [0:`DMEM_WORDS-1];

    // power-up contents
    initial begin
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // ****************************************
    // write port, per-byte enables
    // ****************************************
    always_ff @(posedge clk) begin
        if (ram_wr_en) begin
            for (int b = 0; b < `XLEN/8; b++) begin
                if (ram_wmask[b]) begin
                    mem[ram_index][b*8 +: 8] <= ram_wdata[b*8 +: 8];
                end
            end
        end
    end

    // read port, data holds until the next read
    always_ff @(posedge clk) begin
        if (ram_rd_en) begin
            ram_rdata <= mem[ram_index];
        end
    end

endmodule

/* hdl/lsu_align.sv */
// store lane placement and byte mask, store-data forwarding, load extraction
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module lsu_align import mem_stage_pkg::*; (
    input  rv_inst_u                   held_inst,
    input  logic [`XLEN-1:0]           held_alu_result,   // byte address
    input  logic [`XLEN-1:0]           held_store_data,
    input  logic                       wb_wen,
    input  logic [`REG_ADDR_BITS-1:0]  wb_rd,
    input  logic [`XLEN-1:0]           wb_data,
    output logic [`DMEM_ADDR_BITS-1:0] ram_index,
    output logic [`XLEN-1:0]           ram_wdata,
    output logic [7:0]                 ram_wmask,
    input  logic [`XLEN-1:0]           ram_rdata,
    output logic [`XLEN-1:0]           load_data
);

    logic [2:0]       funct3;       // width in 1:0, unsigned in 2
    logic [4:0]       rs2;
    logic [2:0]       offset;       // byte lane inside the word
    logic [5:0]       lane_shift;   // same offset in bits
    logic             fwd_hit;
    logic [`XLEN-1:0] store_src;
    logic [7:0]       size_mask;    // lanes touched, before the shift
    logic [`XLEN-1:0] rd_lane;      // load lane moved down to bit 0

    assign funct3     = held_inst.store_view.funct3;
    assign rs2        = held_inst.store_view.rs2;
    assign offset     = held_alu_result[2:0];
    assign lane_shift = {offset, 3'b000};
    assign ram_index  = held_alu_result[3 +: `DMEM_ADDR_BITS];   // word address

    // ****************************************
    // store side
    // ****************************************
    // writeback stage value is newer than the one captured at issue
    assign fwd_hit   = wb_wen && (wb_rd == rs2) && (rs2 != 5'd0);
    assign store_src = fwd_hit ? wb_data : held_store_data;

    always_comb begin
        case (funct3[1:0])
            2'd0:    size_mask = 8'h01;   // sb
            2'd1:    size_mask = 8'h03;   // sh
            2'd2:    size_mask = 8'h0f;   // sw
            default: size_mask = 8'hff;   // sd
        endcase
    end

    // aligned only, so the lane never crosses the word
    assign ram_wdata = store_src << lane_shift;
    assign ram_wmask = size_mask << offset;

    // ****************************************
    // load side
    // ****************************************
    assign rd_lane = ram_rdata >> lane_shift;

    always_comb begin
        case (funct3)
            3'b000:  load_data = {{(`XLEN-8){rd_lane[7]}}, rd_lane[7:0]};     // lb
            3'b001:  load_data = {{(`XLEN-16){rd_lane[15]}}, rd_lane[15:0]};  // lh
            3'b010:  load_data = {{(`XLEN-32){rd_lane[31]}}, rd_lane[31:0]};  // lw
            3'b100:  load_data = {{(`XLEN-8){1'b0}}, rd_lane[7:0]};           // lbu
            3'b101:  load_data = {{(`XLEN-16){1'b0}}, rd_lane[15:0]};         // lhu
            3'b110:  load_data = {{(`XLEN-32){1'b0}}, rd_lane[31:0]};         // lwu
            default: load_data = rd_lane;                                     // ld
        endcase
    end

endmodule

/* hdl/mem_access_fsm.sv */
// load/store sequencer, IDLE, WAIT, ACCESS and DONE, plus output valid
`timescale 1ns/1ps

module mem_access_fsm import mem_stage_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      held_valid,
    input  op_class_e held_class,
    input  logic      out_ready,
    input  logic      timer_done,
    output logic      timer_start,
    output logic      ram_rd_en,
    output logic      ram_wr_en,
    output logic      out_valid,
    output logic      out_fire
);

    // ****************************************
    // state encoding
    // ****************************************
    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_WAIT   = 2'd1;   // timer running
    localparam logic [1:0] S_ACCESS = 2'd2;   // one RAM cycle
    localparam logic [1:0] S_DONE   = 2'd3;   // result ready, waiting for sink

    logic [1:0] state;
    logic [1:0] state_nxt;
    logic       is_mem;

    assign is_mem = (held_class == CLASS_LOAD) || (held_class == CLASS_STORE);

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:   if (held_valid && is_mem) state_nxt = S_WAIT;
            S_WAIT:   if (timer_done) state_nxt = S_ACCESS;
            S_ACCESS: state_nxt = S_DONE;
            S_DONE:   if (out_fire) state_nxt = S_IDLE;
            default:  state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // kick the timer on the first cycle a memory op sits here
    assign timer_start = (state == S_IDLE) && held_valid && is_mem;

    // single-cycle strobes, so a stalled store writes once
    assign ram_rd_en = (state == S_ACCESS) && (held_class == CLASS_LOAD);
    assign ram_wr_en = (state == S_ACCESS) && (held_class == CLASS_STORE);

    // non-memory ops go straight through
    assign out_valid = held_valid && (is_mem ? (state == S_DONE) : 1'b1);
    assign out_fire  = out_valid && out_ready;

endmodule

/* hdl/mem_pipe_reg.sv */
// execute-to-memory pipeline register, input handshake and class decode
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module mem_pipe_reg import mem_stage_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [`XLEN-1:0] in_pc,
    input  rv_inst_u         in_inst,
    input  logic [`XLEN-1:0] in_alu_result,
    input  logic [`XLEN-1:0] in_store_data,
    input  logic             out_fire,        // instruction leaves this cycle
    output logic             held_valid,
    output logic [`XLEN-1:0] held_pc,
    output rv_inst_u         held_inst,
    output logic [`XLEN-1:0] held_alu_result,
    output logic [`XLEN-1:0] held_store_data,
    output op_class_e        held_class
);

    op_class_e in_class;    // class of the incoming word
    logic      in_fire;

    // empty, or draining in this same cycle
    assign in_ready = !held_valid || out_fire;
    assign in_fire  = in_valid && in_ready;

    // decode once at capture, downstream only sees the class
    always_comb begin
        case (in_inst.reg_view.opcode)
            OPC_OP, OPC_OP_IMM, OPC_OP_32, OPC_OP_IMM_32,
            OPC_LUI, OPC_AUIPC: in_class = CLASS_ALU;
            OPC_JAL, OPC_JALR:  in_class = CLASS_LINK;
            OPC_LOAD:           in_class = CLASS_LOAD;
            OPC_STORE:          in_class = CLASS_STORE;
            default:            in_class = CLASS_NONE;   // unknown, pass through
        endcase
    end

    // control flags
    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid <= 1'b0;
            held_class <= CLASS_NONE;
        end else if (in_fire) begin
            held_valid <= 1'b1;     // new word wins over a leaving one
            held_class <= in_class;
        end else if (out_fire) begin
            held_valid <= 1'b0;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (in_fire) begin
            held_pc         <= in_pc;
            held_inst       <= in_inst;
            held_alu_result <= in_alu_result;   // also the memory address
            held_store_data <= in_store_data;
        end
    end

endmodule

/* hdl/mem_stage_pkg.sv */
// opcode enum, operation class enum and instruction word union
package mem_stage_pkg;

    // ****************************************
    // major opcodes, bits 6:0 of the word
    // ****************************************
    typedef enum logic [6:0] {
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP_32     = 7'b0111011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111
    } rv_opcode_e;

    // what the stage does with the instruction
    typedef enum logic [2:0] {
        CLASS_NONE  = 3'd0,     // no writeback, no memory
        CLASS_ALU   = 3'd1,     // writes execute result
        CLASS_LINK  = 3'd2,     // writes pc + 4
        CLASS_LOAD  = 3'd3,
        CLASS_STORE = 3'd4
    } op_class_e;

    // one instruction word, two decodings
    typedef union packed {
        struct packed {
            logic [6:0]  funct7;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;       // writeback destination
            rv_opcode_e  opcode;
        } reg_view;
        struct packed {
            logic [6:0]  imm_hi;
            logic [4:0]  rs2;      // store data source
            logic [4:0]  rs1;
            logic [2:0]  funct3;   // access width, bit 2 = unsigned
            logic [4:0]  imm_lo;
            rv_opcode_e  opcode;
        } store_view;
    } rv_inst_u;

endpackage

/* hdl/mem_stage_top.sv */
// memory stage top level, pipeline register, sequencer, timer, LSU, RAM, writeback
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module mem_stage_top import mem_stage_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    // from execute
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [`XLEN-1:0]          in_pc,
    input  rv_inst_u                  in_inst,
    input  logic [`XLEN-1:0]          in_alu_result,
    input  logic [`XLEN-1:0]          in_store_data,
    // to writeback
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic [`XLEN-1:0]          out_pc,
    output rv_inst_u                  out_inst,
    output logic                      reg_wen,
    output logic [`REG_ADDR_BITS-1:0] reg_rd,
    output logic [`XLEN-1:0]          reg_wdata,
    // writeback stage's current write, for store data
    input  logic                      wb_wen,
    input  logic [`REG_ADDR_BITS-1:0] wb_rd,
    input  logic [`XLEN-1:0]          wb_data
);

    // ****************************************
    // internal nets
    // ****************************************
    logic                       held_valid;
    logic [`XLEN-1:0]           held_alu_result;
    logic [`XLEN-1:0]           held_store_data;
    op_class_e                  held_class;
    logic                       out_fire;
    logic                       timer_start;
    logic                       timer_done;
    logic                       ram_rd_en;
    logic                       ram_wr_en;
    logic [`DMEM_ADDR_BITS-1:0] ram_index;
    logic [`XLEN-1:0]           ram_wdata;
    logic [7:0]                 ram_wmask;
    logic [`XLEN-1:0]           ram_rdata;
    logic [`XLEN-1:0]           load_data;

    // held pc and word go straight out to writeback
    mem_pipe_reg u_pipe_reg (
        .clk, .rst, .in_valid, .in_ready, .in_pc, .in_inst,
        .in_alu_result, .in_store_data, .out_fire, .held_valid,
        .held_pc(out_pc), .held_inst(out_inst),
        .held_alu_result, .held_store_data, .held_class
    );

    mem_access_fsm u_fsm (
        .clk, .rst, .held_valid, .held_class, .out_ready, .timer_done,
        .timer_start, .ram_rd_en, .ram_wr_en, .out_valid, .out_fire
    );

    wait_timer u_timer (.clk, .rst, .timer_start, .timer_done);

    lsu_align u_lsu (
        .held_inst(out_inst), .held_alu_result, .held_store_data,
        .wb_wen, .wb_rd, .wb_data, .ram_index, .ram_wdata, .ram_wmask,
        .ram_rdata, .load_data
    );

    data_ram u_ram (.clk, .ram_rd_en, .ram_wr_en, .ram_index, .ram_wdata, .ram_wmask, .ram_rdata);

    wb_select u_wb_sel (
        .held_valid, .held_class, .held_inst(out_inst), .held_pc(out_pc),
        .held_alu_result, .load_data, .out_valid, .reg_wen, .reg_rd, .reg_wdata
    );

endmodule

/* hdl/wait_timer.sv */
// down-counter timing the fixed memory wait cycles
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module wait_timer (
    input  logic clk,
    input  logic rst,
    input  logic timer_start,
    output logic timer_done
);

    localparam int CNT_W = $clog2(`MEM_WAIT_CYCLES + 1);
    localparam logic [CNT_W-1:0] LOAD_VAL = CNT_W'(`MEM_WAIT_CYCLES - 1);

    logic [CNT_W-1:0] cnt;
    logic             idle;     // high when no count is in flight

    // done lands MEM_WAIT_CYCLES cycles after the start strobe
    assign timer_done = !idle && (cnt == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            idle <= 1'b1;
        end else if (timer_start) begin
            cnt  <= LOAD_VAL;
            idle <= 1'b0;
        end else if (timer_done) begin
            idle <= 1'b1;           // one done pulse only
        end else if (!idle) begin
            cnt  <= cnt - CNT_W'(1);
        end
    end

endmodule

/* hdl/wb_select.sv */
// register writeback enable, destination and value mux
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module wb_select import mem_stage_pkg::*; (
    input  logic                      held_valid,
    input  op_class_e                 held_class,
    input  rv_inst_u                  held_inst,
    input  logic [`XLEN-1:0]          held_pc,
    input  logic [`XLEN-1:0]          held_alu_result,
    input  logic [`XLEN-1:0]          load_data,
    input  logic                      out_valid,
    output logic                      reg_wen,
    output logic [`REG_ADDR_BITS-1:0] reg_rd,
    output logic [`XLEN-1:0]          reg_wdata
);

    logic             live;     // a result is on the output this cycle
    logic             wen_raw;
    logic [`XLEN-1:0] wdata_raw;

    assign live = out_valid && held_valid;

    // value by class
    always_comb begin
        wen_raw   = 1'b1;
        wdata_raw = held_alu_result;
        case (held_class)
            CLASS_ALU:  wdata_raw = held_alu_result;
            CLASS_LINK: wdata_raw = held_pc + `XLEN'(4);   // return address
            CLASS_LOAD: wdata_raw = load_data;
            default: begin                                // store, none
                wen_raw   = 1'b0;
                wdata_raw = '0;
            end
        endcase
    end

    // quiet bus while nothing is offered
    assign reg_wen   = live && wen_raw;
    assign reg_rd    = live ? held_inst.reg_view.rd : '0;
    assign reg_wdata = live ? wdata_raw : '0;

endmodule

/* include/mem_stage_params.svh */
// width, RAM size and memory wait-cycle macros for the memory stage
`ifndef MEM_STAGE_PARAMS_SVH
`define MEM_STAGE_PARAMS_SVH

// ****************************************
// datapath
// ****************************************
`define XLEN            64      // data and address width
`define REG_ADDR_BITS   5       // register file index

// ****************************************
// data RAM
// ****************************************
`define DMEM_WORDS      256     // 64-bit words
`define DMEM_ADDR_BITS  8       // word index width, log2 of DMEM_WORDS

// fixed latency stand-in for the data cache
`define MEM_WAIT_CYCLES 2       // must be at least 1

`endif

/* mem_stage_top.f */
+incdir+include
hdl/mem_stage_pkg.sv
hdl/mem_pipe_reg.sv
hdl/mem_access_fsm.sv
hdl/wait_timer.sv
hdl/lsu_align.sv
hdl/data_ram.sv
hdl/wb_select.sv
hdl/mem_stage_top.sv
verification/mem_stage_tb.sv

/* verification/mem_stage_tb.sv */
// clock, reset, LCG stimulus, reference model, output checker and watchdog for the memory stage
`timescale 1ns/1ps
`include "mem_stage_params.svh"

module mem_stage_tb;

    // ****************************************
    // run length and timing
    // ****************************************
    localparam real CLK_PERIOD   = 8.0;
    localparam int  RESET_CYCLES = 8;
    localparam int  ADDR_SPAN    = 64;     // bytes, small so loads hit earlier stores
    localparam int  N_ALU        = 30;
    localparam int  N_WIDTH      = 8;      // per width or load kind
    localparam int  N_FWD        = 16;     // store + load pairs
    localparam int  N_BP         = 200;
    localparam int  N_TOTAL      = N_ALU + 11 * N_WIDTH + 2 * N_FWD + N_BP;
    localparam real TIMEOUT_NS   =
        (N_TOTAL * (`MEM_WAIT_CYCLES + 8) + RESET_CYCLES) * CLK_PERIOD;

    // RV64 major opcodes
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;

    logic                      clk;
    logic                      rst;
    logic                      in_valid;
    logic                      in_ready;
    logic [`XLEN-1:0]          in_pc;
    logic [31:0]               in_inst;
    logic [`XLEN-1:0]          in_alu_result;
    logic [`XLEN-1:0]          in_store_data;
    logic                      out_valid;
    logic                      out_ready;
    logic [`XLEN-1:0]          out_pc;
    logic [31:0]               out_inst;
    logic                      reg_wen;
    logic [`REG_ADDR_BITS-1:0] reg_rd;
    logic [`XLEN-1:0]          reg_wdata;
    logic                      wb_wen;
    logic [`REG_ADDR_BITS-1:0] wb_rd;
    logic [`XLEN-1:0]          wb_data;

    logic [63:0] stim_state;
    logic [63:0] ready_state  = 64'd31034 ^ 64'hA5A5_0000_0000_0000;  // second stream
    logic        ready_random = 1'b0;      // random out_ready once set
    logic [7:0]  mem_model [0:`DMEM_WORDS*8-1];   // byte-addressed shadow of the RAM

    // expected transfers, oldest first
    logic [63:0] exp_pc [$];
    logic [31:0] exp_inst [$];
    logic        exp_wen [$];
    logic [4:0]  exp_rd [$];
    logic [63:0] exp_wdata [$];

    int          sent_count  = 0;
    int          out_count   = 0;
    int          error_count = 0;
    logic        prev_stall  = 1'b0;       // offered but not taken last cycle
    logic [63:0] prev_pc     = '0;
    logic        cur_wen;
    logic [4:0]  cur_rd;
    logic [63:0] cur_wdata;

    mem_stage_top dut_i (
        .clk, .rst, .in_valid, .in_ready, .in_pc, .in_inst, .in_alu_result,
        .in_store_data, .out_valid, .out_ready, .out_pc, .out_inst,
        .reg_wen, .reg_rd, .reg_wdata, .wb_wen, .wb_rd, .wb_data
    );

    // ****************************************
    // helpers
    // ****************************************
    function automatic logic [63:0] lcg_next(input logic [63:0] s);
        return s * 64'd6364136223846793005 + 64'd1442695040888963407;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_state = lcg_next(stim_state);
        return stim_state[63:32];      // high half, low bits are weak
    endfunction

    function automatic logic [10:0] aligned_addr(input logic [2:0] f3);
        logic [10:0] r;
        r = 11'(next_rand() % ADDR_SPAN);
        return r & ~11'((1 << f3[1:0]) - 1);   // natural alignment
    endfunction

    function automatic logic [6:0] alu_opcode(input int sel);
        case (sel)
            0:       return OPC_OP;
            1:       return OPC_OP_IMM;
            2:       return OPC_OP_32;
            3:       return OPC_OP_IMM_32;
            4:       return OPC_LUI;
            default: return OPC_AUIPC;
        endcase
    endfunction

    // expected {wen, value}, stores update the shadow memory
    function automatic logic [64:0] ref_writeback(
        input logic [63:0] pc, input logic [31:0] inst, input logic [63:0] alu,
        input logic [63:0] sdata, input logic fwd_wen, input logic [4:0] fwd_rd,
        input logic [63:0] fwd_data
    );
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [4:0]  rs2;
        logic [63:0] data;
        logic [63:0] val;
        int          nbytes;
        int          base;
        opc    = inst[6:0];
        f3     = inst[14:12];
        rs2    = inst[24:20];
        nbytes = 1 << f3[1:0];
        base   = int'(alu[10:0]);
        val    = '0;
        case (opc)
            OPC_LOAD: begin
                for (int i = 0; i < nbytes; i++) begin
                    val[i*8 +: 8] = mem_model[base + i];
                end
                if (!f3[2] && nbytes < 8 && val[nbytes*8-1]) begin
                    val = val | ~((64'd1 << (nbytes * 8)) - 64'd1);   // sign fill
                end
                return {1'b1, val};
            end
            OPC_STORE: begin
                // writeback stage result wins over the captured rs2 value
                data = (fwd_wen && fwd_rd == rs2 && rs2 != 5'd0) ? fwd_data : sdata;
                for (int i = 0; i < nbytes; i++) begin
                    mem_model[base + i] = data[i*8 +: 8];
                end
                return {1'b0, 64'd0};
            end
            OPC_JAL, OPC_JALR: return {1'b1, pc + 64'd4};
            OPC_OP, OPC_OP_IMM, OPC_OP_32, OPC_OP_IMM_32,
            OPC_LUI, OPC_AUIPC: return {1'b1, alu};
            default: return {1'b0, 64'd0};
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display(">>> FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run("output value mismatch");
        end
    endtask

    // ****************************************
    // driver, called 1 ns after an edge
    // ****************************************
    task automatic send(input logic [63:0] pc, input logic [31:0] inst,
                        input logic [63:0] alu, input logic [63:0] sdata,
                        input logic wwen, input logic [4:0] wrd, input logic [63:0] wdata);
        logic [64:0] expv;
        in_valid      = 1'b1;
        in_pc         = pc;
        in_inst       = inst;
        in_alu_result = alu;
        in_store_data = sdata;
        wb_wen        = wwen;
        wb_rd         = wrd;
        wb_data       = wdata;
        @(negedge clk);
        while (!in_ready) @(negedge clk);      // ready is settled mid-cycle
        @(posedge clk);                        // transfer on this edge
        expv = ref_writeback(pc, inst, alu, sdata, wwen, wrd, wdata);
        exp_pc.push_back(pc);
        exp_inst.push_back(inst);
        exp_wen.push_back(expv[64]);
        exp_rd.push_back(inst[11:7]);
        exp_wdata.push_back(expv[63:0]);
        sent_count++;
        #1;
        in_valid = 1'b0;
        // forwarding inputs stay put until the store is gone
        if (inst[6:0] == OPC_STORE) begin
            while (out_count < sent_count) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    // kind 0 alu, 1 link, 2 load, 3 store; fwd 0 off, 1 hit rs2, 2 random
    task automatic issue(input int kind, input logic [2:0] f3, input logic [10:0] addr,
                         input int fwd);
        logic [6:0]  opc;
        logic [4:0]  rs2;
        logic [4:0]  wrd;
        logic        wwen;
        logic [31:0] inst;
        logic [63:0] alu;
        rs2 = 5'(next_rand());
        if (fwd == 1 && next_rand() % 4 == 0) begin
            rs2 = 5'd0;                        // x0 never forwards
        end
        case (kind)
            0:       opc = alu_opcode(int'(next_rand() % 6));
            1:       opc = (next_rand() % 2 != 0) ? OPC_JAL : OPC_JALR;
            2:       opc = OPC_LOAD;
            default: opc = OPC_STORE;
        endcase
        inst = {7'(next_rand()), rs2, 5'(next_rand()), f3, 5'(next_rand()), opc};
        alu  = (kind >= 2) ? {53'd0, addr} : {next_rand(), next_rand()};
        wwen = (fwd == 1) ? 1'b1 : (fwd == 2) ? (next_rand() % 2 != 0) : 1'b0;
        wrd  = (fwd == 1 || (fwd == 2 && next_rand() % 2 != 0)) ? rs2 : 5'(next_rand());
        send({next_rand(), next_rand()} & ~64'h3, inst, alu, {next_rand(), next_rand()},
             wwen, wrd, {next_rand(), next_rand()});
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // sink side, full speed until the back-pressure phase
    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (ready_random) begin
                ready_state = lcg_next(ready_state);
                out_ready   = (ready_state[63:62] != 2'b00);   // about 3 in 4
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        abort_run("watchdog timeout, the DUT stopped moving instructions");
    end

    // ****************************************
    // output checker
    // ****************************************
    // mid-cycle sample, the transfer itself is on the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (prev_stall) begin
                check_value("out_valid held under back-pressure", 64'(out_valid), 64'd1);
                check_value("out_pc held under back-pressure", out_pc, prev_pc);
            end
            if (!out_valid) begin
                check_value("reg_wen while out_valid is low", 64'(reg_wen), 64'd0);
            end
            if (out_valid && out_ready) begin
                if (exp_pc.size() == 0) begin
                    abort_run("output transfer with no instruction outstanding");
                end else begin
                    cur_wen   = exp_wen.pop_front();
                    cur_rd    = exp_rd.pop_front();
                    cur_wdata = exp_wdata.pop_front();
                    check_value("out_pc", out_pc, exp_pc.pop_front());
                    check_value("out_inst", {32'd0, out_inst}, {32'd0, exp_inst.pop_front()});
                    check_value("reg_wen", 64'(reg_wen), 64'(cur_wen));
                    if (cur_wen) begin
                        check_value("reg_rd", 64'(reg_rd), 64'(cur_rd));
                        check_value("reg_wdata", reg_wdata, cur_wdata);
                    end
                    out_count++;
                end
            end
            prev_stall = out_valid && !out_ready;
            prev_pc    = out_pc;
        end
    end

    // ****************************************
    // test sequence
    // ****************************************
    initial begin
        int          kind;
        logic [2:0]  f3;
        logic [10:0] a;
        stim_state    = 64'd31034;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_pc         = '0;
        in_inst       = '0;
        in_alu_result = '0;
        in_store_data = '0;
        wb_wen        = 1'b0;
        wb_rd         = '0;
        wb_data       = '0;
        for (int i = 0; i < `DMEM_WORDS * 8; i++) begin
            mem_model[i] = 8'h00;              // RAM powers up zero
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle outputs after reset
        check_value("out_valid after reset", 64'(out_valid), 64'd0);
        check_value("reg_wen after reset", 64'(reg_wen), 64'd0);
        check_value("in_ready after reset", 64'(in_ready), 64'd1);

        // alu, link and plain stores
        for (int n = 0; n < N_ALU; n++) begin
            kind = int'(next_rand() % 3);
            f3   = 3'(next_rand() % 4);
            issue((kind == 2) ? 3 : kind, f3, aligned_addr(f3), 0);
        end

        // every store width, then every load kind
        for (int w = 0; w < 4; w++) begin
            for (int n = 0; n < N_WIDTH; n++) begin
                issue(3, 3'(w), aligned_addr(3'(w)), 0);
            end
        end
        for (int w = 0; w < 7; w++) begin
            for (int n = 0; n < N_WIDTH; n++) begin
                issue(2, 3'(w), aligned_addr(3'(w)), 0);
            end
        end

        // forwarded store read straight back
        for (int n = 0; n < N_FWD; n++) begin
            f3 = 3'(next_rand() % 4);
            a  = aligned_addr(f3);
            issue(3, f3, a, 1);
            issue(2, f3, a, 0);
        end

        // full mix with a stalling sink
        ready_random = 1'b1;
        for (int n = 0; n < N_BP; n++) begin
            kind = int'(next_rand() % 4);
            f3   = (kind == 2) ? 3'(next_rand() % 7) : 3'(next_rand() % 4);
            issue(kind, f3, aligned_addr(f3), 2);
        end

        while (out_count < sent_count) begin
            @(posedge clk);
            #1;
        end
        if (error_count == 0 && exp_pc.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("instructions left over or errors counted at the end of the run");
        end
    end

endmodule
